// File: rtl/eth_stat_pkg.sv
// Shared definitions for the receive statistics subsystem.
// Holds the lane count, the counter width, the XGMII control characters,
// the lane monitor states and the APB register map.
// Modules refer to these items by scoped name.

package eth_stat_pkg;

    // Number of XGMII receive lanes handled by the core.
    localparam int num_lanes = 4;

    // Width of each frame and error counter.
    localparam int cnt_width = 32;

    // ************************************************************
    // XGMII control characters
    // ************************************************************

    typedef enum logic [7:0] {
        ctrl_idle  = 8'h07,
        ctrl_start = 8'hFB,
        ctrl_term  = 8'hFD,
        ctrl_error = 8'hFE
    } xgmii_ctrl_t;

    // Lane monitor states.
    typedef enum logic {
        st_idle,
        st_frame
    } rx_state_t;

    // ************************************************************
    // APB register offsets
    // ************************************************************

    // Lane n counters sit at the base offsets plus 8 times n.
    typedef enum logic [7:0] {
        reg_status      = 8'h00,
        reg_clear       = 8'h04,
        reg_frames_base = 8'h10,
        reg_errors_base = 8'h14
    } reg_addr_t;

endpackage

// File: rtl/sync_reset.sv
// Reset synchronizer for the statistics logic.
// The output asserts as soon as arst_n falls and releases only after
// the chain has filled with ones, sync_stages clock edges later.

`timescale 1ns/1ps

module sync_reset #(
    parameter int sync_stages = 4
) (
    input  logic clk,
    input  logic arst_n,
    output logic rst_n_sync
);

    logic [sync_stages-1:0] chain;

    // Ones shift in from the bottom once the external reset is gone.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chain <= '0;
        end else begin
            chain <= (chain << 1) | sync_stages'(1);
        end
    end

    // The last stage is the clean reset for the rest of the design.
    assign rst_n_sync = chain[sync_stages-1];

endmodule

// File: rtl/xgmii_rx_monitor.sv
// Per-lane XGMII receive monitor.
// Decodes start, terminate and error control characters on a 64-bit
// XGMII word and counts good and errored frames in saturating counters.
// A clear pulse from the register block zeroes both counters.

`timescale 1ns/1ps

module xgmii_rx_monitor #(
    parameter int cnt_width = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [63:0]          rxd,
    input  logic [7:0]           rxc,
    input  logic                 block_lock,
    input  logic                 clear,
    output logic [cnt_width-1:0] frame_count,
    output logic [cnt_width-1:0] error_count
);

    eth_stat_pkg::rx_state_t state;
    eth_stat_pkg::rx_state_t state_next;

    logic bad;
    logic bad_next;
    logic has_start;
    logic has_term;
    logic has_err;
    logic inc_good;
    logic inc_err;

    // ************************************************************
    // Word decode
    // ************************************************************

    // Start is only recognized in byte 0.
    assign has_start = rxc[0] && (rxd[7:0] == eth_stat_pkg::ctrl_start);

    always_comb begin
        has_term = 1'b0;
        has_err  = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (rxc[i] && (rxd[8*i +: 8] == eth_stat_pkg::ctrl_term)) begin
                has_term = 1'b1;
            end
            if (rxc[i] && (rxd[8*i +: 8] == eth_stat_pkg::ctrl_error)) begin
                has_err = 1'b1;
            end
        end
    end

    // ************************************************************
    // Frame tracking
    // ************************************************************

    always_comb begin
        state_next = state;
        bad_next   = bad;
        inc_good   = 1'b0;
        inc_err    = 1'b0;

        if (!block_lock) begin
            // The open frame is lost with the lock and is not counted.
            state_next = eth_stat_pkg::st_idle;
            bad_next   = 1'b0;
        end else if (has_start) begin
            // A second start closes the open frame as an errored one.
            if (state == eth_stat_pkg::st_frame) begin
                inc_err = 1'b1;
            end
            state_next = eth_stat_pkg::st_frame;
            bad_next   = has_err;
        end else if (state == eth_stat_pkg::st_frame) begin
            if (has_term) begin
                if (bad || has_err) begin
                    inc_err = 1'b1;
                end else begin
                    inc_good = 1'b1;
                end
                state_next = eth_stat_pkg::st_idle;
                bad_next   = 1'b0;
            end else begin
                bad_next = bad || has_err;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= eth_stat_pkg::st_idle;
            bad   <= 1'b0;
        end else begin
            state <= state_next;
            bad   <= bad_next;
        end
    end

    // ************************************************************
    // Counters
    // ************************************************************

    // Clear takes priority over a count in the same cycle.
    // Both counters hold at all ones.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_count <= '0;
            error_count <= '0;
        end else if (clear) begin
            frame_count <= '0;
            error_count <= '0;
        end else begin
            if (inc_good && (frame_count != '1)) begin
                frame_count <= frame_count + 1'b1;
            end
            if (inc_err && (error_count != '1)) begin
                error_count <= error_count + 1'b1;
            end
        end
    end

endmodule

// File: rtl/eth_stat_regs.sv
// APB status block for the receive statistics.
// Reads return the lock bits and the per-lane frame and error counters;
// a write to the clear register pulses the lane clear lines for one cycle.
// The block also drives the user LEDs from the lock flags.
// There are no wait states, so pready is high in every access phase.

`timescale 1ns/1ps

module eth_stat_regs #(
    parameter int num_lanes = 4,
    parameter int cnt_width = 32
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [7:0]                     paddr,
    input  logic [31:0]                    pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  logic [num_lanes-1:0]           block_lock,
    input  logic [num_lanes*cnt_width-1:0] frame_counts,
    input  logic [num_lanes*cnt_width-1:0] error_counts,
    output logic [num_lanes-1:0]           clear,
    output logic [num_lanes-1:0]           user_led
);

    logic        access;
    logic        mapped;
    logic        is_clear;
    logic [31:0] rd_data;

    assign access = psel && penable;

    // ************************************************************
    // Address decode and read mux
    // ************************************************************

    always_comb begin
        rd_data  = '0;
        mapped   = 1'b0;
        is_clear = 1'b0;

        case (paddr)
            eth_stat_pkg::reg_status: begin
                rd_data[num_lanes-1:0] = block_lock;
                mapped = 1'b1;
            end
            eth_stat_pkg::reg_clear: begin
                mapped   = 1'b1;
                is_clear = 1'b1;
            end
            default: begin
                // Counter pairs are laid out 8 bytes apart per lane.
                for (int n = 0; n < num_lanes; n++) begin
                    if (paddr == 8'(eth_stat_pkg::reg_frames_base + 8 * n)) begin
                        rd_data = 32'(frame_counts[n*cnt_width +: cnt_width]);
                        mapped  = 1'b1;
                    end
                    if (paddr == 8'(eth_stat_pkg::reg_errors_base + 8 * n)) begin
                        rd_data = 32'(error_counts[n*cnt_width +: cnt_width]);
                        mapped  = 1'b1;
                    end
                end
            end
        endcase
    end

    assign prdata  = rd_data;
    assign pready  = access;

    // The clear register is write-only, so reading it is an error.
    assign pslverr = access && (!mapped || (is_clear && !pwrite));

    // ************************************************************
    // Clear pulse and LEDs
    // ************************************************************

    // The access phase lasts one cycle, so the pulse does too.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clear <= '0;
        end else if (access && pwrite && is_clear) begin
            clear <= pwdata[num_lanes-1:0];
        end else begin
            clear <= '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            user_led <= '0;
        end else begin
            user_led <= block_lock;
        end
    end

endmodule

// File: rtl/eth_stat_core.sv
// Top level of the quad-lane receive statistics subsystem.
// Takes the XGMII receive lanes and block lock flags, counts frames per
// lane and makes the counts available over APB.
// All lanes share one clock; the reset is synchronized once for all.

`timescale 1ns/1ps

module eth_stat_core #(
    parameter int sync_stages = 4,
    parameter int num_lanes   = eth_stat_pkg::num_lanes,
    parameter int cnt_width   = eth_stat_pkg::cnt_width
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [num_lanes*64-1:0] rxd,
    input  logic [num_lanes*8-1:0]  rxc,
    input  logic [num_lanes-1:0]    block_lock,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [7:0]              paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic [num_lanes-1:0]    user_led
);

    logic                           rst_n_sync;
    logic [num_lanes-1:0]           clear;
    logic [num_lanes*cnt_width-1:0] frame_counts;
    logic [num_lanes*cnt_width-1:0] error_counts;

    sync_reset #(
        .sync_stages(sync_stages)
    ) sync_reset_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .rst_n_sync(rst_n_sync)
    );

    // One monitor per lane.
    for (genvar n = 0; n < num_lanes; n++) begin : g_lane
        xgmii_rx_monitor #(
            .cnt_width(cnt_width)
        ) monitor_inst (
            .clk        (clk),
            .arst_n     (rst_n_sync),
            .rxd        (rxd[n*64 +: 64]),
            .rxc        (rxc[n*8 +: 8]),
            .block_lock (block_lock[n]),
            .clear      (clear[n]),
            .frame_count(frame_counts[n*cnt_width +: cnt_width]),
            .error_count(error_counts[n*cnt_width +: cnt_width])
        );
    end

    eth_stat_regs #(
        .num_lanes(num_lanes),
        .cnt_width(cnt_width)
    ) regs_inst (
        .clk         (clk),
        .arst_n      (rst_n_sync),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .block_lock  (block_lock),
        .frame_counts(frame_counts),
        .error_counts(error_counts),
        .clear       (clear),
        .user_led    (user_led)
    );

endmodule

// File: sim/tb_eth_stat.sv
// Testbench for the quad-lane receive statistics core.
// Drives XGMII words on all lanes from an xorshift generator, keeps the
// expected counts in a reference model and reads the counters over APB.
// Compile with the file list tb.f from the project root; top is tb_eth_stat.

`timescale 1ns/1ps

module tb_eth_stat;

    localparam int lanes   = eth_stat_pkg::num_lanes;
    localparam int k_idle  = 0;
    localparam int k_start = 1;
    localparam int k_data  = 2;
    localparam int k_error = 3;
    localparam int k_term  = 4;

    // Stimulus phases, six counter sweeps of ten idles and eight reads,
    // and a handful of single register accesses.
    localparam int stim_cycles = 200 + 300 + 100 + 10;
    localparam int read_cycles = 6 * (10 + 2 * lanes * 3) + 40;
    localparam int cycle_limit = 2 * (stim_cycles + read_cycles) + 200;

    logic                  clk;
    logic                  arst_n;
    logic [lanes*64-1:0]   rxd;
    logic [lanes*8-1:0]    rxc;
    logic [lanes-1:0]      block_lock;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [7:0]            paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic [lanes-1:0]      user_led;

    logic [31:0]           rng = 32'd98;
    logic [lanes-1:0]      lock_mask;
    logic [31:0]           ref_frames[lanes];
    logic [31:0]           ref_errors[lanes];
    bit                    ref_in_frame[lanes];
    bit                    ref_bad[lanes];
    int                    cycles = 0;
    int                    checks = 0;
    int                    mismatches = 0;
    int                    failures = 0;
    logic [31:0]           rd;

    eth_stat_core dut (
        .clk(clk), .arst_n(arst_n), .rxd(rxd), .rxc(rxc), .block_lock(block_lock),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .user_led(user_led)
    );

    always #2 clk = ~clk;

    // ************************************************************
    // Random source, word builder and reference model
    // ************************************************************

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Returns {rxc, rxd} for one word of the given kind.
    function automatic logic [71:0] make_word(input int kind, input logic [31:0] r);
        logic [63:0] d;
        logic [7:0]  c;
        d = {r, ~r};
        c = 8'h00;
        if (kind == k_idle) begin
            d = {8{8'h07}};
            c = 8'hFF;
        end else if (kind == k_start) begin
            d[7:0] = eth_stat_pkg::ctrl_start;
            c = 8'h01;
        end else if (kind == k_error) begin
            d[31:24] = eth_stat_pkg::ctrl_error;
            c = 8'h08;
        end else if (kind == k_term) begin
            d[63:32] = {8'h07, 8'h07, 8'h07, 8'(eth_stat_pkg::ctrl_term)};
            c = 8'hF0;
        end
        return {c, d};
    endfunction

    // Expected counts per lane, following the frame delimiter rules.
    function automatic void ref_step(input int lane, input int kind, input bit lock);
        if (!lock) begin
            ref_in_frame[lane] = 1'b0;
            ref_bad[lane] = 1'b0;
        end else if (kind == k_start) begin
            if (ref_in_frame[lane] && ref_errors[lane] != '1) begin
                ref_errors[lane] = ref_errors[lane] + 1;
            end
            ref_in_frame[lane] = 1'b1;
            ref_bad[lane] = 1'b0;
        end else if (ref_in_frame[lane] && kind == k_term) begin
            if (ref_bad[lane] && ref_errors[lane] != '1) begin
                ref_errors[lane] = ref_errors[lane] + 1;
            end else if (!ref_bad[lane] && ref_frames[lane] != '1) begin
                ref_frames[lane] = ref_frames[lane] + 1;
            end
            ref_in_frame[lane] = 1'b0;
            ref_bad[lane] = 1'b0;
        end else if (ref_in_frame[lane] && kind == k_error) begin
            ref_bad[lane] = 1'b1;
        end
    endfunction

    // ************************************************************
    // Drivers and checks
    // ************************************************************

    // Mode 0 gives clean frames, mode 1 the full menu, mode 2 the fixed kind.
    task automatic drive_lanes(input int mode, input int fixed_kind);
        logic [71:0] w;
        int          kind;
        @(negedge clk);
        block_lock = lock_mask;
        for (int n = 0; n < lanes; n++) begin
            rng = xorshift(rng);
            if (mode == 0) begin
                if (ref_in_frame[n]) begin
                    kind = (rng[1:0] == 2'b00) ? k_term : k_data;
                end else begin
                    kind = rng[0] ? k_start : k_idle;
                end
            end else if (mode == 1) begin
                kind = int'(rng[15:8]) % 5;
            end else begin
                kind = fixed_kind;
            end
            w = make_word(kind, rng);
            rxd[n*64 +: 64] = w[63:0];
            rxc[n*8 +: 8] = w[71:64];
            ref_step(n, kind, lock_mask[n]);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic access_check(input logic exp_err);
        checks++;
        if (pready !== 1'b1) begin
            failures++;
            $display("At %0t pready was not high in an APB access phase", $time);
        end
        check_value("pslverr", 32'(exp_err), 32'(pslverr));
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err,
                            output logic [31:0] data);
        @(negedge clk);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        access_check(exp_err);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        access_check(1'b0);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic check_counters();
        logic [31:0] data;
        repeat (10) drive_lanes(2, k_idle);
        for (int n = 0; n < lanes; n++) begin
            apb_read(8'(eth_stat_pkg::reg_frames_base + 8 * n), 1'b0, data);
            check_value($sformatf("frame_count[%0d]", n), ref_frames[n], data);
            apb_read(8'(eth_stat_pkg::reg_errors_base + 8 * n), 1'b0, data);
            check_value($sformatf("error_count[%0d]", n), ref_errors[n], data);
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // ************************************************************
    // Test sequence
    // ************************************************************

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        rxd = {lanes{64'h0707_0707_0707_0707}};
        rxc = '1;
        block_lock = '0;
        lock_mask = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        for (int n = 0; n < lanes; n++) begin
            ref_frames[n] = '0;
            ref_errors[n] = '0;
            ref_in_frame[n] = 1'b0;
            ref_bad[n] = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // After reset everything reads zero.
        check_counters();
        apb_read(eth_stat_pkg::reg_status, 1'b0, rd);
        check_value("status", 32'h0, rd);
        check_value("user_led", 32'h0, 32'(user_led));

        lock_mask = '1;
        repeat (200) drive_lanes(0, k_idle);
        check_counters();
        repeat (300) drive_lanes(1, k_idle);
        check_counters();

        // Lane 2 loses lock in the middle of a frame.
        drive_lanes(2, k_start);
        drive_lanes(2, k_data);
        lock_mask = 4'b1011;
        drive_lanes(2, k_idle);
        apb_read(eth_stat_pkg::reg_status, 1'b0, rd);
        check_value("status", 32'hB, rd);
        check_value("user_led", 32'hB, 32'(user_led));
        lock_mask = '1;
        drive_lanes(2, k_data);
        drive_lanes(2, k_term);
        check_counters();
        check_value("user_led", 32'hF, 32'(user_led));

        // Clearing lane 1 leaves the other lanes alone.
        apb_write(eth_stat_pkg::reg_clear, 32'h2);
        ref_frames[1] = '0;
        ref_errors[1] = '0;
        check_counters();
        repeat (100) drive_lanes(1, k_idle);
        check_counters();

        apb_read(8'h08, 1'b1, rd);
        apb_read(eth_stat_pkg::reg_clear, 1'b1, rd);

        $display("Summary: %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
rtl/eth_stat_pkg.sv
rtl/sync_reset.sv
rtl/xgmii_rx_monitor.sv
rtl/eth_stat_regs.sv
rtl/eth_stat_core.sv
sim/tb_eth_stat.sv
